//--- bench/tb_tile_mem_map.sv
module tb_tile_mem_map;
  import mem_msg_pkg::*;

  localparam int TIMEOUT     = 2000;
  localparam int MAX_ENTRIES = 16;

  logic                  clk;
  logic                  rst;
  logic                  cmd_valid;
  logic                  cmd_ready;
  mem_opcode_e           cmd_opcode;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [ID_WIDTH-1:0]   cmd_id;
  logic [DATA_WIDTH-1:0] cmd_data;
  logic                  resp_valid;
  logic                  resp_ready;
  mem_opcode_e           resp_opcode;
  logic [ADDR_WIDTH-1:0] resp_addr;
  logic [ID_WIDTH-1:0]   resp_id;
  logic [DATA_WIDTH-1:0] resp_data;
  logic                  mem_cmd_valid;
  logic                  mem_cmd_ready;
  mem_opcode_e           mem_cmd_opcode;
  logic [ADDR_WIDTH-1:0] mem_cmd_addr;
  logic [ID_WIDTH-1:0]   mem_cmd_id;
  logic [DATA_WIDTH-1:0] mem_cmd_data;
  logic                  mem_resp_valid;
  logic                  mem_resp_ready;
  mem_opcode_e           mem_resp_opcode;
  logic [ADDR_WIDTH-1:0] mem_resp_addr;
  logic [ID_WIDTH-1:0]   mem_resp_id;
  logic [DATA_WIDTH-1:0] mem_resp_data;
  logic                  timer_irq;
  logic                  software_irq;

  // Stimulus table indexed by command id
  mem_opcode_e           t_op   [MAX_ENTRIES];
  logic [ADDR_WIDTH-1:0] t_addr [MAX_ENTRIES];
  logic [DATA_WIDTH-1:0] t_data [MAX_ENTRIES];
  logic [DATA_WIDTH-1:0] t_exp  [MAX_ENTRIES];
  int                    t_mode [MAX_ENTRIES];   // 0 unchecked, 1 equal, 2 at least
  logic                  t_ext  [MAX_ENTRIES];
  logic                  t_sync [MAX_ENTRIES];
  int                    t_sw   [MAX_ENTRIES];   // -1 means not checked
  int                    t_tm   [MAX_ENTRIES];
  int                    n_entries;

  logic                  got_resp [MAX_ENTRIES];
  logic                  mem_seen [MAX_ENTRIES];
  logic [DATA_WIDTH-1:0] ext_mem  [16];
  int                    received;
  int                    checks;
  int                    errors;
  int                    rid;
  int                    mid;
  logic [31:0]           lfsr;
  logic                  resp_done;
  logic                  cmd_take;
  logic                  rnd;
  mem_opcode_e           cap_op;
  logic [ADDR_WIDTH-1:0] cap_addr;
  logic [ID_WIDTH-1:0]   cap_id;
  logic [DATA_WIDTH-1:0] cap_data;

  tile_mem_map dut (
    .clk_i (clk), .rst_i (rst),
    .cmd_valid_i (cmd_valid), .cmd_ready_o (cmd_ready), .cmd_opcode_i (cmd_opcode),
    .cmd_addr_i (cmd_addr), .cmd_id_i (cmd_id), .cmd_data_i (cmd_data),
    .resp_valid_o (resp_valid), .resp_ready_i (resp_ready), .resp_opcode_o (resp_opcode),
    .resp_addr_o (resp_addr), .resp_id_o (resp_id), .resp_data_o (resp_data),
    .mem_cmd_valid_o (mem_cmd_valid), .mem_cmd_ready_i (mem_cmd_ready),
    .mem_cmd_opcode_o (mem_cmd_opcode), .mem_cmd_addr_o (mem_cmd_addr),
    .mem_cmd_id_o (mem_cmd_id), .mem_cmd_data_o (mem_cmd_data),
    .mem_resp_valid_i (mem_resp_valid), .mem_resp_ready_o (mem_resp_ready),
    .mem_resp_opcode_i (mem_resp_opcode), .mem_resp_addr_i (mem_resp_addr),
    .mem_resp_id_i (mem_resp_id), .mem_resp_data_i (mem_resp_data),
    .timer_irq_o (timer_irq), .software_irq_o (software_irq)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic add_entry(input mem_opcode_e op, input logic [31:0] addr,
                           input logic [63:0] data, input logic [63:0] exp, input int mode,
                           input logic ext, input logic sync, input int sw, input int tm);
    t_op[n_entries]   = op;
    t_addr[n_entries] = addr;
    t_data[n_entries] = data;
    t_exp[n_entries]  = exp;
    t_mode[n_entries] = mode;
    t_ext[n_entries]  = ext;
    t_sync[n_entries] = sync;
    t_sw[n_entries]   = sw;
    t_tm[n_entries]   = tm;
    n_entries++;
  endtask

  task automatic send(input int i);
    int   t;
    logic fired;
    t     = 0;
    fired = 1'b0;
    @(negedge clk);
    cmd_valid  = 1'b1;
    cmd_opcode = t_op[i];
    cmd_addr   = t_addr[i];
    cmd_id     = i[ID_WIDTH-1:0];
    cmd_data   = t_data[i];
    while (!fired)
    begin
      @(posedge clk);
      fired = cmd_ready;   // Pre-edge value
      t++;
      if (t > TIMEOUT)
        stop_on_timeout("cmd_ready_o");
    end
  endtask

  task automatic wait_responses(input int target);
    int t;
    t = 0;
    while (received < target)
    begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT)
        stop_on_timeout("responses");
    end
  endtask

  // External memory model with one response in flight
  always
  begin
    @(posedge clk);
    resp_done = mem_resp_valid && mem_resp_ready;
    cmd_take  = mem_cmd_valid && mem_cmd_ready;
    if (cmd_take)
    begin
      cap_op   = mem_cmd_opcode;
      cap_addr = mem_cmd_addr;
      cap_id   = mem_cmd_id;
      cap_data = mem_cmd_data;
    end
    @(negedge clk);
    if (resp_done)
      mem_resp_valid = 1'b0;
    if (cmd_take)
    begin
      if (cap_op == MEM_WRITE)
        ext_mem[cap_addr[6:3]] = cap_data;
      mem_resp_valid  = 1'b1;
      mem_resp_opcode = cap_op;
      mem_resp_addr   = cap_addr;
      mem_resp_id     = cap_id;
      mem_resp_data   = (cap_op == MEM_WRITE) ? '0 : ext_mem[cap_addr[6:3]];
    end
    take_bit(rnd);
    mem_cmd_ready = rnd & ~mem_resp_valid;
    take_bit(rnd);
    resp_ready = rnd;
  end

  // Response and external command monitor
  always @(posedge clk)
  begin
    if (!rst && resp_valid && resp_ready)
    begin
      rid = int'(resp_id);
      if (rid >= n_entries || got_resp[rid])
      begin
        errors++;
        $display("Unexpected or repeated response with id %0d at time %0t", rid, $time);
      end
      else
      begin
        got_resp[rid] = 1'b1;
        received++;
        compare("response opcode", 64'(resp_opcode), 64'(t_op[rid]));
        compare("response address", 64'(resp_addr), 64'(t_addr[rid]));
        if (t_mode[rid] == 1)
          compare("response data", resp_data, t_exp[rid]);
        else if (t_mode[rid] == 2)
          compare("response data at least", 64'(resp_data >= t_exp[rid]), 64'd1);
        compare("external route", 64'(mem_seen[rid]), 64'(t_ext[rid]));
      end
    end
    if (!rst && mem_cmd_valid && mem_cmd_ready)
    begin
      mid = int'(mem_cmd_id);
      if (mid >= n_entries || !t_ext[mid])
      begin
        errors++;
        $display("Internal command with id %0d reached external memory", mid);
      end
      else
      begin
        mem_seen[mid] = 1'b1;
        compare("mem_cmd opcode", 64'(mem_cmd_opcode), 64'(t_op[mid]));
        compare("mem_cmd address", 64'(mem_cmd_addr), 64'(t_addr[mid]));
        compare("mem_cmd data", mem_cmd_data, t_data[mid]);
      end
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd_opcode = MEM_READ;
    cmd_addr = '0;
    cmd_id = '0;
    cmd_data = '0;
    resp_ready = 1'b0;
    mem_cmd_ready = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_opcode = MEM_READ;
    mem_resp_addr = '0;
    mem_resp_id = '0;
    mem_resp_data = '0;
    lfsr = 32'hea3c_409a;
    received = 0;
    checks = 0;
    errors = 0;
    n_entries = 0;
    for (int i = 0; i < MAX_ENTRIES; i++)
    begin
      got_resp[i] = 1'b0;
      mem_seen[i] = 1'b0;
    end
    for (int i = 0; i < 16; i++)
      ext_mem[i] = {16{i[3:0]}};

    add_entry(MEM_WRITE, 32'h0010_0008, 64'ha5a5_0123_4567_89ab, '0, 1, 0, 0, -1, -1);
    add_entry(MEM_READ,  32'h0010_0008, '0, 64'ha5a5_0123_4567_89ab, 1, 0, 0, -1, -1);
    add_entry(MEM_WRITE, 32'h8000_0040, 64'hdead_beef_0000_1111, '0, 1, 1, 0, -1, -1);
    add_entry(MEM_READ,  32'h8000_0040, '0, 64'hdead_beef_0000_1111, 1, 1, 0, -1, -1);
    add_entry(MEM_WRITE, 32'h0030_0018, 64'hcafe_f00d_2222_3333, '0, 1, 1, 0, -1, -1);
    add_entry(MEM_READ,  32'h0030_0018, '0, 64'hcafe_f00d_2222_3333, 1, 1, 0, -1, -1);
    add_entry(MEM_READ,  32'h9000_0048, '0, 64'h9999_9999_9999_9999, 1, 1, 0, -1, -1);
    add_entry(MEM_READ,  32'h0050_0000, '0, '0, 1, 0, 0, -1, -1);
    add_entry(MEM_WRITE, 32'h0070_0100, 64'hffff, '0, 1, 0, 0, -1, -1);
    add_entry(MEM_WRITE, 32'h0020_0000, 64'd1, '0, 1, 0, 1, 1, 0);   // msip
    add_entry(MEM_WRITE, 32'h0020_0000, 64'd0, '0, 1, 0, 1, 0, 0);
    add_entry(MEM_WRITE, 32'h0020_4000, 64'd0, '0, 1, 0, 1, 0, 1);   // mtimecmp
    add_entry(MEM_WRITE, 32'h0020_4000, '1, '0, 1, 0, 1, 0, 0);
    add_entry(MEM_WRITE, 32'h0020_bff8, 64'h1000, '0, 1, 0, 0, -1, -1);   // mtime
    add_entry(MEM_READ,  32'h0020_bff8, '0, 64'h1000, 2, 0, 0, -1, -1);

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    compare("timer_irq_o after reset", 64'(timer_irq), 64'd0);
    compare("software_irq_o after reset", 64'(software_irq), 64'd0);

    for (int i = 0; i < n_entries; i++)
    begin
      send(i);
      if (t_sync[i])
      begin
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_responses(i + 1);
        if (t_sw[i] >= 0)
          compare("software_irq_o", 64'(software_irq), 64'(t_sw[i]));
        if (t_tm[i] >= 0)
          compare("timer_irq_o", 64'(timer_irq), 64'(t_tm[i]));
      end
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    wait_responses(n_entries);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- bench/tile_mem_map_checker.sv
module tile_mem_map_checker (
  input logic                               clk_i,
  input logic                               rst_r_i,
  input logic                               resp_valid_o,
  input logic                               resp_ready_i,
  input mem_msg_pkg::mem_opcode_e           resp_opcode_o,
  input logic [mem_msg_pkg::ADDR_WIDTH-1:0] resp_addr_o,
  input logic [mem_msg_pkg::ID_WIDTH-1:0]   resp_id_o,
  input logic [mem_msg_pkg::DATA_WIDTH-1:0] resp_data_o,
  input logic                               mem_cmd_valid_o,
  input logic                               mem_cmd_ready_i
);

  // Response held until the requester takes it
  a_resp_hold: assert property (@(posedge clk_i) disable iff (rst_r_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_opcode_o)
      && $stable(resp_addr_o) && $stable(resp_id_o) && $stable(resp_data_o))
    else $error("response changed while stalled");

  a_mem_cmd_hold: assert property (@(posedge clk_i) disable iff (rst_r_i)
    mem_cmd_valid_o && !mem_cmd_ready_i |=> mem_cmd_valid_o)
    else $error("mem_cmd_valid_o dropped before acceptance");

  // Registered reset needs one cycle to reach the buffer
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_r_i && $past(rst_r_i) |-> !resp_valid_o && !mem_cmd_valid_o)
    else $error("valid raised during reset");

endmodule

bind tile_mem_map tile_mem_map_checker checker_i (.*, .rst_r_i(rst_r));

//--- hdl/cfg_regs.sv
module cfg_regs (
  input logic       clk_i,
  input logic       rst_i,
  mem_msg_if.sink   cmd_i,
  mem_msg_if.source resp_o
);
  import mem_msg_pkg::*;
  import mem_map_pkg::*;

  logic [DATA_WIDTH-1:0]    regs_q [CFG_REG_COUNT];
  logic [CFG_IDX_WIDTH-1:0] idx;
  logic                     is_write;
  logic                     cmd_fire;
  logic                     resp_valid_q;
  mem_hdr_s                 resp_hdr_q;
  logic [DATA_WIDTH-1:0]    resp_data_q;

  assign idx         = cmd_i.hdr.addr.raw[CFG_IDX_LSB +: CFG_IDX_WIDTH];
  assign is_write    = (cmd_i.hdr.opcode == MEM_WRITE);
  assign cmd_i.ready = ~resp_valid_q;   // One response in flight
  assign cmd_fire    = cmd_i.valid & cmd_i.ready;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < CFG_REG_COUNT; i++)
        regs_q[i] <= '0;
    end
    else if (cmd_fire && is_write)
      regs_q[idx] <= cmd_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_valid_q <= 1'b0;
    else if (cmd_fire)
      resp_valid_q <= 1'b1;
    else if (resp_o.ready)
      resp_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_hdr_q  <= cmd_i.hdr;
      resp_data_q <= is_write ? '0 : regs_q[idx];
    end
  end

  assign resp_o.valid = resp_valid_q;
  assign resp_o.hdr   = resp_hdr_q;
  assign resp_o.data  = resp_data_q;

endmodule

//--- hdl/clint_timer.sv
module clint_timer (
  input  logic      clk_i,
  input  logic      rst_i,
  mem_msg_if.sink   cmd_i,
  mem_msg_if.source resp_o,
  output logic      timer_irq_o,
  output logic      software_irq_o
);
  import mem_msg_pkg::*;
  import mem_map_pkg::*;

  logic [DATA_WIDTH-1:0] mtime_q;
  logic [DATA_WIDTH-1:0] mtimecmp_q;
  logic                  msip_q;
  logic                  cmd_fire;
  logic                  wr_en;
  logic                  hit_msip;
  logic                  hit_cmp;
  logic                  hit_mtime;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  resp_valid_q;
  mem_hdr_s              resp_hdr_q;
  logic [DATA_WIDTH-1:0] resp_data_q;

  assign cmd_i.ready = ~resp_valid_q;
  assign cmd_fire    = cmd_i.valid & cmd_i.ready;
  assign wr_en       = cmd_fire & (cmd_i.hdr.opcode == MEM_WRITE);

  assign hit_msip  = (cmd_i.hdr.addr.map.offset == CLINT_MSIP_OFFSET);
  assign hit_cmp   = (cmd_i.hdr.addr.map.offset == CLINT_MTIMECMP_OFFSET);
  assign hit_mtime = (cmd_i.hdr.addr.map.offset == CLINT_MTIME_OFFSET);

  always_comb
  begin
    rd_data = '0;   // Unknown offsets read as zero
    if (hit_msip)
      rd_data = {{(DATA_WIDTH-1){1'b0}}, msip_q};
    else if (hit_cmp)
      rd_data = mtimecmp_q;
    else if (hit_mtime)
      rd_data = mtime_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;   // No timer interrupt out of reset
      msip_q     <= 1'b0;
    end
    else
    begin
      if (wr_en && hit_mtime)
        mtime_q <= cmd_i.data;
      else
        mtime_q <= mtime_q + 1'b1;
      if (wr_en && hit_cmp)
        mtimecmp_q <= cmd_i.data;
      if (wr_en && hit_msip)
        msip_q <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_valid_q <= 1'b0;
    else if (cmd_fire)
      resp_valid_q <= 1'b1;
    else if (resp_o.ready)
      resp_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_hdr_q  <= cmd_i.hdr;
      resp_data_q <= (cmd_i.hdr.opcode == MEM_WRITE) ? '0 : rd_data;
    end
  end

  assign resp_o.valid = resp_valid_q;
  assign resp_o.hdr   = resp_hdr_q;
  assign resp_o.data  = resp_data_q;

  assign timer_irq_o    = (mtime_q >= mtimecmp_q);
  assign software_irq_o = msip_q;

endmodule

//--- hdl/loopback_sink.sv
module loopback_sink (
  input logic       clk_i,
  input logic       rst_i,
  mem_msg_if.sink   cmd_i,
  mem_msg_if.source resp_o
);
  import mem_msg_pkg::*;

  logic     cmd_fire;
  logic     resp_valid_q;
  mem_hdr_s resp_hdr_q;

  assign cmd_i.ready = ~resp_valid_q;
  assign cmd_fire    = cmd_i.valid & cmd_i.ready;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_valid_q <= 1'b0;
    else if (cmd_fire)
      resp_valid_q <= 1'b1;
    else if (resp_o.ready)
      resp_valid_q <= 1'b0;
  end

  // Only the header comes back
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      resp_hdr_q <= cmd_i.hdr;
  end

  assign resp_o.valid = resp_valid_q;
  assign resp_o.hdr   = resp_hdr_q;
  assign resp_o.data  = '0;

endmodule

//--- hdl/mem_cmd_dispatch.sv
module mem_cmd_dispatch (
  mem_msg_if.sink                            cmd_i,
  mem_msg_if.source                          cfg_o,
  mem_msg_if.source                          clint_o,
  mem_msg_if.source                          loop_o,
  output logic                               ext_valid_o,
  input  logic                               ext_ready_i,
  output mem_msg_pkg::mem_hdr_s              ext_hdr_o,
  output logic [mem_msg_pkg::DATA_WIDTH-1:0] ext_data_o
);
  import mem_map_pkg::*;

  logic is_local;
  logic is_cfg;
  logic is_clint;
  logic is_ext;
  logic is_loop;

  assign is_local = (cmd_i.hdr.addr.raw < DRAM_BASE);
  assign is_cfg   = is_local && (cmd_i.hdr.addr.map.device == CFG_DEV);
  assign is_clint = is_local && (cmd_i.hdr.addr.map.device == CLINT_DEV);
  assign is_ext   = !is_local || (cmd_i.hdr.addr.map.device == CACHE_DEV);
  assign is_loop  = is_local && !is_cfg && !is_clint && !is_ext;

  // Any busy target stalls the whole command port
  assign cmd_i.ready = cfg_o.ready & clint_o.ready & loop_o.ready & ext_ready_i;

  // A target only sees valid once the other three are ready, so it never
  // takes a command that the requester still holds
  assign cfg_o.valid   = cmd_i.valid & is_cfg & clint_o.ready & loop_o.ready & ext_ready_i;
  assign clint_o.valid = cmd_i.valid & is_clint & cfg_o.ready & loop_o.ready & ext_ready_i;
  assign loop_o.valid  = cmd_i.valid & is_loop & cfg_o.ready & clint_o.ready & ext_ready_i;
  assign ext_valid_o   = cmd_i.valid & is_ext & cfg_o.ready & clint_o.ready & loop_o.ready;

  assign cfg_o.hdr   = cmd_i.hdr;
  assign clint_o.hdr = cmd_i.hdr;
  assign loop_o.hdr  = cmd_i.hdr;
  assign ext_hdr_o   = cmd_i.hdr;

  assign cfg_o.data   = cmd_i.data;
  assign clint_o.data = cmd_i.data;
  assign loop_o.data  = cmd_i.data;
  assign ext_data_o   = cmd_i.data;

endmodule

//--- hdl/mem_map_pkg.sv
package mem_map_pkg;

  // At or above this goes to external memory
  localparam logic [31:0] DRAM_BASE = 32'h8000_0000;

  // Device field values of local addresses
  localparam logic [3:0] CFG_DEV   = 4'd1;
  localparam logic [3:0] CLINT_DEV = 4'd2;
  localparam logic [3:0] CACHE_DEV = 4'd3;

  // Configuration register file
  localparam int CFG_REG_COUNT = 8;
  localparam int CFG_IDX_WIDTH = $clog2(CFG_REG_COUNT);
  localparam int CFG_IDX_LSB   = 3;   // Doubleword registers

  // Timer register offsets
  localparam logic [19:0] CLINT_MSIP_OFFSET     = 20'h0_0000;
  localparam logic [19:0] CLINT_MTIMECMP_OFFSET = 20'h0_4000;
  localparam logic [19:0] CLINT_MTIME_OFFSET    = 20'h0_bff8;

endpackage

//--- hdl/mem_msg_if.sv
interface mem_msg_if;
  import mem_msg_pkg::*;

  logic                  valid;
  logic                  ready;
  mem_hdr_s              hdr;
  logic [DATA_WIDTH-1:0] data;

  modport source (
    output valid, hdr, data,
    input  ready
  );

  modport sink (
    input  valid, hdr, data,
    output ready
  );

endinterface

//--- hdl/mem_msg_pkg.sv
package mem_msg_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 64;
  localparam int ID_WIDTH   = 4;   // Requester tag, echoed in every response

  typedef enum logic [1:0] {
    MEM_READ  = 2'b00,
    MEM_WRITE = 2'b01
  } mem_opcode_e;

  // Local memory map view of an address
  typedef struct packed {
    logic [7:0]  upper;
    logic [3:0]  device;   // Bits 23 to 20
    logic [19:0] offset;
  } mem_map_view_s;

  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    mem_map_view_s         map;
  } mem_addr_u;

  typedef struct packed {
    mem_opcode_e         opcode;
    mem_addr_u           addr;
    logic [ID_WIDTH-1:0] id;
  } mem_hdr_s;

endpackage

//--- hdl/mem_resp_arbiter.sv
module mem_resp_arbiter (
  input  logic                               ext_valid_i,
  output logic                               ext_ready_o,
  input  mem_msg_pkg::mem_hdr_s              ext_hdr_i,
  input  logic [mem_msg_pkg::DATA_WIDTH-1:0] ext_data_i,
  mem_msg_if.sink                            cfg_i,
  mem_msg_if.sink                            clint_i,
  mem_msg_if.sink                            loop_i,
  mem_msg_if.source                          resp_o
);

  assign resp_o.valid = ext_valid_i | cfg_i.valid | clint_i.valid | loop_i.valid;

  // Fixed priority, external memory first
  assign ext_ready_o   = resp_o.ready & ext_valid_i;
  assign cfg_i.ready   = resp_o.ready & cfg_i.valid & ~ext_valid_i;
  assign clint_i.ready = resp_o.ready & clint_i.valid & ~ext_valid_i & ~cfg_i.valid;
  assign loop_i.ready  = resp_o.ready & loop_i.valid & ~ext_valid_i & ~cfg_i.valid
                         & ~clint_i.valid;

  always_comb
  begin
    if (ext_valid_i)
    begin
      resp_o.hdr  = ext_hdr_i;
      resp_o.data = ext_data_i;
    end
    else if (cfg_i.valid)
    begin
      resp_o.hdr  = cfg_i.hdr;
      resp_o.data = cfg_i.data;
    end
    else if (clint_i.valid)
    begin
      resp_o.hdr  = clint_i.hdr;
      resp_o.data = clint_i.data;
    end
    else
    begin
      resp_o.hdr  = loop_i.hdr;
      resp_o.data = loop_i.data;
    end
  end

endmodule

//--- hdl/resp_two_fifo.sv
module resp_two_fifo (
  input logic       clk_i,
  input logic       rst_i,
  mem_msg_if.sink   in_i,
  mem_msg_if.source out_o
);
  import mem_msg_pkg::*;

  mem_hdr_s              hdr_mem [2];
  logic [DATA_WIDTH-1:0] data_mem [2];
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic                  full_q;
  logic                  empty_q;
  logic                  wr_en;
  logic                  rd_en;

  // Full still takes a write when the head leaves in the same cycle
  assign in_i.ready = ~full_q | out_o.ready;
  assign wr_en      = in_i.valid & in_i.ready;
  assign rd_en      = ~empty_q & out_o.ready;

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      hdr_mem[wr_ptr_q]  <= in_i.hdr;
      data_mem[wr_ptr_q] <= in_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= ~wr_ptr_q;
      if (rd_en)
        rd_ptr_q <= ~rd_ptr_q;
      if (wr_en && !rd_en)
      begin
        empty_q <= 1'b0;
        full_q  <= (wr_ptr_q != rd_ptr_q);   // Second entry filled
      end
      else if (rd_en && !wr_en)
      begin
        full_q  <= 1'b0;
        empty_q <= (wr_ptr_q != rd_ptr_q);   // Last entry drained
      end
    end
  end

  assign out_o.valid = ~empty_q;
  assign out_o.hdr   = hdr_mem[rd_ptr_q];
  assign out_o.data  = data_mem[rd_ptr_q];

endmodule

//--- hdl/tile_mem_map.sv
module tile_mem_map (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               cmd_valid_i,
  output logic                               cmd_ready_o,
  input  mem_msg_pkg::mem_opcode_e           cmd_opcode_i,
  input  logic [mem_msg_pkg::ADDR_WIDTH-1:0] cmd_addr_i,
  input  logic [mem_msg_pkg::ID_WIDTH-1:0]   cmd_id_i,
  input  logic [mem_msg_pkg::DATA_WIDTH-1:0] cmd_data_i,
  output logic                               resp_valid_o,
  input  logic                               resp_ready_i,
  output mem_msg_pkg::mem_opcode_e           resp_opcode_o,
  output logic [mem_msg_pkg::ADDR_WIDTH-1:0] resp_addr_o,
  output logic [mem_msg_pkg::ID_WIDTH-1:0]   resp_id_o,
  output logic [mem_msg_pkg::DATA_WIDTH-1:0] resp_data_o,
  output logic                               mem_cmd_valid_o,
  input  logic                               mem_cmd_ready_i,
  output mem_msg_pkg::mem_opcode_e           mem_cmd_opcode_o,
  output logic [mem_msg_pkg::ADDR_WIDTH-1:0] mem_cmd_addr_o,
  output logic [mem_msg_pkg::ID_WIDTH-1:0]   mem_cmd_id_o,
  output logic [mem_msg_pkg::DATA_WIDTH-1:0] mem_cmd_data_o,
  input  logic                               mem_resp_valid_i,
  output logic                               mem_resp_ready_o,
  input  mem_msg_pkg::mem_opcode_e           mem_resp_opcode_i,
  input  logic [mem_msg_pkg::ADDR_WIDTH-1:0] mem_resp_addr_i,
  input  logic [mem_msg_pkg::ID_WIDTH-1:0]   mem_resp_id_i,
  input  logic [mem_msg_pkg::DATA_WIDTH-1:0] mem_resp_data_i,
  output logic                               timer_irq_o,
  output logic                               software_irq_o
);
  import mem_msg_pkg::*;

  logic     rst_r;
  mem_hdr_s ext_cmd_hdr;
  mem_hdr_s ext_resp_hdr;

  mem_msg_if cmd_if ();
  mem_msg_if cfg_cmd_if ();
  mem_msg_if clint_cmd_if ();
  mem_msg_if loop_cmd_if ();
  mem_msg_if cfg_resp_if ();
  mem_msg_if clint_resp_if ();
  mem_msg_if loop_resp_if ();
  mem_msg_if arb_if ();
  mem_msg_if out_if ();

  always_ff @(posedge clk_i)
    rst_r <= rst_i;   // One extra cycle of reset

  assign cmd_if.valid           = cmd_valid_i;
  assign cmd_if.hdr.opcode      = cmd_opcode_i;
  assign cmd_if.hdr.addr.raw    = cmd_addr_i;
  assign cmd_if.hdr.id          = cmd_id_i;
  assign cmd_if.data            = cmd_data_i;
  assign cmd_ready_o            = cmd_if.ready;

  assign mem_cmd_opcode_o       = ext_cmd_hdr.opcode;
  assign mem_cmd_addr_o         = ext_cmd_hdr.addr.raw;
  assign mem_cmd_id_o           = ext_cmd_hdr.id;
  assign ext_resp_hdr.opcode    = mem_resp_opcode_i;
  assign ext_resp_hdr.addr.raw  = mem_resp_addr_i;
  assign ext_resp_hdr.id        = mem_resp_id_i;

  mem_cmd_dispatch dispatch (
    .cmd_i       (cmd_if.sink),
    .cfg_o       (cfg_cmd_if.source),
    .clint_o     (clint_cmd_if.source),
    .loop_o      (loop_cmd_if.source),
    .ext_valid_o (mem_cmd_valid_o),
    .ext_ready_i (mem_cmd_ready_i),
    .ext_hdr_o   (ext_cmd_hdr),
    .ext_data_o  (mem_cmd_data_o)
  );

  cfg_regs cfg (
    .clk_i  (clk_i),
    .rst_i  (rst_r),
    .cmd_i  (cfg_cmd_if.sink),
    .resp_o (cfg_resp_if.source)
  );

  clint_timer clint (
    .clk_i          (clk_i),
    .rst_i          (rst_r),
    .cmd_i          (clint_cmd_if.sink),
    .resp_o         (clint_resp_if.source),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  loopback_sink loopback (
    .clk_i  (clk_i),
    .rst_i  (rst_r),
    .cmd_i  (loop_cmd_if.sink),
    .resp_o (loop_resp_if.source)
  );

  mem_resp_arbiter resp_arb (
    .ext_valid_i (mem_resp_valid_i),
    .ext_ready_o (mem_resp_ready_o),
    .ext_hdr_i   (ext_resp_hdr),
    .ext_data_i  (mem_resp_data_i),
    .cfg_i       (cfg_resp_if.sink),
    .clint_i     (clint_resp_if.sink),
    .loop_i      (loop_resp_if.sink),
    .resp_o      (arb_if.source)
  );

  resp_two_fifo resp_fifo (
    .clk_i (clk_i),
    .rst_i (rst_r),
    .in_i  (arb_if.sink),
    .out_o (out_if.source)
  );

  assign resp_valid_o  = out_if.valid;
  assign out_if.ready  = resp_ready_i;
  assign resp_opcode_o = out_if.hdr.opcode;
  assign resp_addr_o   = out_if.hdr.addr.raw;
  assign resp_id_o     = out_if.hdr.id;
  assign resp_data_o   = out_if.data;

endmodule

//--- run.sh
#!/bin/bash
# Build with Verilator and run; status follows the pass message
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f tb.f --top-module tb_tile_mem_map -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tb.f
hdl/mem_msg_pkg.sv
hdl/mem_map_pkg.sv
hdl/mem_msg_if.sv
hdl/mem_cmd_dispatch.sv
hdl/cfg_regs.sv
hdl/clint_timer.sv
hdl/loopback_sink.sv
hdl/mem_resp_arbiter.sv
hdl/resp_two_fifo.sv
hdl/tile_mem_map.sv
bench/tile_mem_map_checker.sv
bench/tb_tile_mem_map.sv
